// ==== all.f ====
+incdir+source
source/ex_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_stage.sv
testbench/tb_clk_gen.sv
testbench/ex_stage_assert.sv
testbench/ex_stage_tb.sv

// ==== source/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_alu
(
  input  logic [`EX_DATA_W-1:0] op_a_i,
  input  logic [`EX_DATA_W-1:0] op_b_i,
  input  ex_pkg::alu_op_e       alu_op_i,
  output logic [`EX_DATA_W-1:0] result_o
);

  localparam int SHAMT_W = $clog2(`EX_DATA_W);

  // Bit order reversal, lets the right shifter do left shifts too
  function automatic logic [`EX_DATA_W-1:0] bit_rev(input logic [`EX_DATA_W-1:0] d);
    logic [`EX_DATA_W-1:0] r;
    for (int i = 0; i < `EX_DATA_W; i++)
    begin
      r[i] = d[`EX_DATA_W-1-i];
    end
    return r;
  endfunction

  logic                  sub_en;
  logic [`EX_DATA_W-1:0] adder_b;
  logic [`EX_DATA_W:0]   adder_sum;
  logic                  overflow;
  logic                  lt_signed;
  logic                  lt_unsigned;

  logic                  shift_left;
  logic                  shift_fill;
  logic [SHAMT_W-1:0]    shift_amt;
  logic [`EX_DATA_W-1:0] shift_in;
  logic [`EX_DATA_W:0]   shift_ext;
  logic [`EX_DATA_W-1:0] shift_out;

  ////////////////////////////////////////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////////////////////////////////////////

  // Subtract for SUB and both compares
  assign sub_en = (alu_op_i == ex_pkg::ALU_SUB) || (alu_op_i == ex_pkg::ALU_SLT) ||
                  (alu_op_i == ex_pkg::ALU_SLTU);

  // Two's complement, invert B and carry in one
  assign adder_b   = sub_en ? ~op_b_i : op_b_i;
  assign adder_sum = {1'b0, op_a_i} + {1'b0, adder_b} + {{`EX_DATA_W{1'b0}}, sub_en};

  // Overflow when operand signs differ and result sign flips away from A
  assign overflow    = (op_a_i[`EX_DATA_W-1] != op_b_i[`EX_DATA_W-1]) &&
                       (adder_sum[`EX_DATA_W-1] != op_a_i[`EX_DATA_W-1]);
  assign lt_signed   = adder_sum[`EX_DATA_W-1] ^ overflow;
  // No carry out means a borrow, so A below B
  assign lt_unsigned = ~adder_sum[`EX_DATA_W];

  ////////////////////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////////////////////

  assign shift_left = (alu_op_i == ex_pkg::ALU_SLL);
  assign shift_amt  = op_b_i[SHAMT_W-1:0];
  // Sign fill only for the arithmetic shift
  assign shift_fill = (alu_op_i == ex_pkg::ALU_SRA) & op_a_i[`EX_DATA_W-1];
  assign shift_in   = shift_left ? bit_rev(op_a_i) : op_a_i;
  assign shift_ext  = $unsigned($signed({shift_fill, shift_in}) >>> shift_amt);
  assign shift_out  = shift_left ? bit_rev(shift_ext[`EX_DATA_W-1:0])
                                 : shift_ext[`EX_DATA_W-1:0];

  // Result select, unused encodings give zero
  always_comb
  begin
    case (alu_op_i)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB:  result_o = adder_sum[`EX_DATA_W-1:0];
      ex_pkg::ALU_AND:  result_o = op_a_i & op_b_i;
      ex_pkg::ALU_OR:   result_o = op_a_i | op_b_i;
      ex_pkg::ALU_XOR:  result_o = op_a_i ^ op_b_i;
      ex_pkg::ALU_SLL,
      ex_pkg::ALU_SRL,
      ex_pkg::ALU_SRA:  result_o = shift_out;
      ex_pkg::ALU_SLT:  result_o = {{(`EX_DATA_W-1){1'b0}}, lt_signed};
      ex_pkg::ALU_SLTU: result_o = {{(`EX_DATA_W-1){1'b0}}, lt_unsigned};
      default:          result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/ex_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_mult
(
  input  ex_pkg::mult_ctrl_t    ctrl_i,
  input  logic [`EX_DATA_W-1:0] op_a_i,
  input  logic [`EX_DATA_W-1:0] op_b_i,
  input  logic [`EX_DATA_W-1:0] mac_i,
  output logic [`EX_DATA_W-1:0] result_o
);

  logic [`EX_DATA_W-1:0] op_a_sel;
  logic [`EX_DATA_W-1:0] op_b_sel;
  logic [`EX_DATA_W-1:0] mac_int;
  logic [`EX_HALF_W-1:0] half_a;
  logic [`EX_HALF_W-1:0] half_b;

  ////////////////////////////////////////////////////////////////////////////
  // Subword selection
  ////////////////////////////////////////////////////////////////////////////

  // Upper or lower halfword of each operand
  assign half_a = ctrl_i.sel_subword[1] ? op_a_i[`EX_DATA_W-1:`EX_HALF_W]
                                        : op_a_i[`EX_HALF_W-1:0];
  assign half_b = ctrl_i.sel_subword[0] ? op_b_i[`EX_DATA_W-1:`EX_HALF_W]
                                        : op_b_i[`EX_HALF_W-1:0];

  always_comb
  begin
    // Full words unless vector mode
    op_a_sel = op_a_i;
    op_b_sel = op_b_i;

    if (ctrl_i.vector_mode)
    begin
      // Zero or sign extension per operand
      op_a_sel = {{(`EX_DATA_W-`EX_HALF_W){ctrl_i.signed_mode[1] & half_a[`EX_HALF_W-1]}},
                  half_a};
      op_b_sel = {{(`EX_DATA_W-`EX_HALF_W){ctrl_i.signed_mode[0] & half_b[`EX_HALF_W-1]}},
                  half_b};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Multiply and accumulate
  ////////////////////////////////////////////////////////////////////////////

  // Addend is zero without accumulate
  assign mac_int = ctrl_i.mac_en ? mac_i : '0;

  // Low half of the product only, wraps modulo 2^32
  assign result_o = mac_int + op_a_sel * op_b_sel;

endmodule

`default_nettype wire

// ==== source/ex_pkg.sv ====
`default_nettype none

`include "ex_settings.svh"

package ex_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // ALU opcodes
  ////////////////////////////////////////////////////////////////////////////

  // Shift amount comes from the low bits of operand B
  // Compares return 1 or 0
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Multiplier control and execute request
  ////////////////////////////////////////////////////////////////////////////

  // Bit 1 of each pair refers to operand A, bit 0 to operand B
  typedef struct packed {
    logic       mac_en;
    logic       vector_mode;
    logic [1:0] sel_subword;
    logic [1:0] signed_mode;
  } mult_ctrl_t;

  // One request into the execute stage, 107 bits
  typedef struct packed {
    logic [`EX_DATA_W-1:0] op_a;
    logic [`EX_DATA_W-1:0] op_b;
    logic [`EX_DATA_W-1:0] op_c;
    alu_op_e               alu_op;
    logic                  mult_sel;
    mult_ctrl_t            mult_ctrl;
  } ex_req_t;

endpackage

`default_nettype wire

// ==== source/ex_settings.svh ====
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Operand and result width of the execute stage
`define EX_DATA_W 32

// Subword width used by the vectorial multiplier
`define EX_HALF_W 16

// Width of the ALU opcode field
`define EX_ALU_OP_W 4

`endif

// ==== source/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_stage
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  req_valid_i,
  input  ex_pkg::ex_req_t       req_i,
  output logic [`EX_DATA_W-1:0] result_o,
  output logic                  result_valid_o
);

  logic [`EX_DATA_W-1:0] alu_result;
  logic [`EX_DATA_W-1:0] mult_result;
  logic [`EX_DATA_W-1:0] unit_result;

  ////////////////////////////////////////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////////////////////////////////////////

  // Integer ALU on operands A and B
  ex_alu alu_i
  (
    .op_a_i   (req_i.op_a),
    .op_b_i   (req_i.op_b),
    .alu_op_i (req_i.alu_op),
    .result_o (alu_result)
  );

  // Multiplier, operand C is the addend
  ex_mult mult_i
  (
    .ctrl_i   (req_i.mult_ctrl),
    .op_a_i   (req_i.op_a),
    .op_b_i   (req_i.op_b),
    .mac_i    (req_i.op_c),
    .result_o (mult_result)
  );

  // Unit select
  assign unit_result = req_i.mult_sel ? mult_result : alu_result;

  ////////////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////////////

  // One cycle latency, strobe high for one cycle per request
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      result_valid_o <= 1'b0;
    end
    else
    begin
      result_valid_o <= req_valid_i;
    end
  end

  // Holds last value while idle
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      result_o <= '0;
    end
    else if (req_valid_i)
    begin
      result_o <= unit_result;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/ex_stage_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_stage_assert
(
  input wire logic                  clk,
  input wire logic                  rst_n_i,
  input wire logic                  req_valid_i,
  input wire logic [`EX_DATA_W-1:0] result_o,
  input wire logic                  result_valid_o
);

  // Failure count, read by the testbench at the end
  int fail_count = 0;

  // No result strobe in the cycle after reset
  valid_low_after_reset: assert property (@(posedge clk) !rst_n_i |=> !result_valid_o)
    else
    begin
      fail_count++;
      $error("result_valid_o high in the cycle after reset");
    end

  // Strobe is the request strobe delayed by one cycle
  valid_follows_req: assert property (@(posedge clk)
    rst_n_i |=> (result_valid_o == $past(req_valid_i)))
    else
    begin
      fail_count++;
      $error("result_valid_o does not follow req_valid_i of the previous cycle");
    end

  // Register holds while idle, reset edge excluded
  result_holds_idle: assert property (@(posedge clk)
    (rst_n_i && $past(rst_n_i) && !result_valid_o) |-> $stable(result_o))
    else
    begin
      fail_count++;
      $error("result_o changed while result_valid_o was low");
    end

endmodule

bind ex_stage ex_stage_assert assert_i
(
  .clk            (clk),
  .rst_n_i        (rst_n_i),
  .req_valid_i    (req_valid_i),
  .result_o       (result_o),
  .result_valid_o (result_valid_o)
);

`default_nettype wire

// ==== testbench/ex_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_stage_tb;

  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int RST_CYCLES  = 5;
  localparam int N_ALU_OPS   = 10;
  localparam int N_CORNER    = 8;
  localparam int N_ALU_RAND  = 6;
  localparam int N_MUL_RAND  = 24;
  localparam int N_VEC_SETS  = 3;
  localparam int N_BURST     = 24;
  localparam int N_GAP       = 3;
  localparam int N_REQ       = N_ALU_OPS * (N_CORNER + N_ALU_RAND) +
                               2 * (N_CORNER + N_MUL_RAND) + N_VEC_SETS * 32 + N_BURST + 1;
  // Each request takes one cycle, plus reset, idle cycles and margin
  localparam int TIMEOUT_NS  = (RST_CYCLES + N_REQ + N_GAP + 50) * CLK_PERIOD;

  // Corner pairs, B also covers shift amounts 0 and 31
  localparam logic [`EX_DATA_W-1:0] CORNER_A [N_CORNER] = '{
    32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
    32'h8000_0000, 32'hffff_ffff, 32'h0000_0001, 32'h1234_5678};
  localparam logic [`EX_DATA_W-1:0] CORNER_B [N_CORNER] = '{
    32'h0000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001,
    32'h0000_001f, 32'h0000_0000, 32'h8000_001f, 32'h0000_0020};

  // Vector operands with the top bit set in both halves
  localparam logic [`EX_DATA_W-1:0] VEC_A [N_VEC_SETS] = '{
    32'h8765_c321, 32'hffff_8000, 32'hc001_9003};
  localparam logic [`EX_DATA_W-1:0] VEC_B [N_VEC_SETS] = '{
    32'hfedc_9abc, 32'h8001_ffff, 32'ha5a5_f00f};
  localparam logic [`EX_DATA_W-1:0] VEC_C [N_VEC_SETS] = '{
    32'hffff_0001, 32'h0001_0000, 32'h8000_0000};

  logic                  clk;
  logic                  rst_n;
  logic                  req_valid;
  ex_pkg::ex_req_t       req;
  logic [`EX_DATA_W-1:0] result;
  logic                  result_valid;
  logic [`EX_DATA_W-1:0] rng_state;

  tb_clk_gen clk_gen_i
  (
    .clk_o (clk)
  );

  ex_stage DUT
  (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .result_o       (result),
    .result_valid_o (result_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////////////////////

  // LCG, numerical recipes constants
  function automatic logic [`EX_DATA_W-1:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [`EX_DATA_W-1:0] alu_model(input logic [`EX_DATA_W-1:0] a,
                                                      input logic [`EX_DATA_W-1:0] b,
                                                      input ex_pkg::alu_op_e op);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_SLL:  return a << sh;
      ex_pkg::ALU_SRL:  return a >> sh;
      ex_pkg::ALU_SRA:  return $unsigned($signed(a) >>> sh);
      ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ex_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:          return 32'd0;
    endcase
  endfunction

  // Product in 64 bits, low word kept
  function automatic logic [`EX_DATA_W-1:0] mult_model(input ex_pkg::mult_ctrl_t ctrl,
                                                       input logic [`EX_DATA_W-1:0] a,
                                                       input logic [`EX_DATA_W-1:0] b,
                                                       input logic [`EX_DATA_W-1:0] c);
    logic [`EX_HALF_W-1:0] ha;
    logic [`EX_HALF_W-1:0] hb;
    longint                ea;
    longint                eb;
    longint                prod;
    ea = longint'(a);
    eb = longint'(b);
    if (ctrl.vector_mode)
    begin
      ha = ctrl.sel_subword[1] ? a[31:16] : a[15:0];
      hb = ctrl.sel_subword[0] ? b[31:16] : b[15:0];
      ea = ctrl.signed_mode[1] ? longint'($signed(ha)) : longint'(ha);
      eb = ctrl.signed_mode[0] ? longint'($signed(hb)) : longint'(hb);
    end
    prod = ea * eb;
    return prod[31:0] + (ctrl.mac_en ? c : 32'd0);
  endfunction

  function automatic logic [`EX_DATA_W-1:0] req_model(input ex_pkg::ex_req_t r);
    if (r.mult_sel)
    begin
      return mult_model(r.mult_ctrl, r.op_a, r.op_b, r.op_c);
    end
    return alu_model(r.op_a, r.op_b, r.alu_op);
  endfunction

  function automatic ex_pkg::mult_ctrl_t make_ctrl(input logic mac, input logic vec,
                                                   input logic [1:0] sel,
                                                   input logic [1:0] sgn);
    ex_pkg::mult_ctrl_t c;
    c.mac_en      = mac;
    c.vector_mode = vec;
    c.sel_subword = sel;
    c.signed_mode = sgn;
    return c;
  endfunction

  function automatic ex_pkg::ex_req_t make_req(input logic [`EX_DATA_W-1:0] a,
                                               input logic [`EX_DATA_W-1:0] b,
                                               input logic [`EX_DATA_W-1:0] c,
                                               input ex_pkg::alu_op_e op,
                                               input logic use_mult,
                                               input ex_pkg::mult_ctrl_t ctrl);
    ex_pkg::ex_req_t r;
    r.op_a      = a;
    r.op_b      = b;
    r.op_c      = c;
    r.alu_op    = op;
    r.mult_sel  = use_mult;
    r.mult_ctrl = ctrl;
    return r;
  endfunction

  // Random operands, opcode and multiplier control
  function automatic ex_pkg::ex_req_t random_req(input logic use_mult);
    logic [`EX_DATA_W-1:0] bits;
    bits = next_rand();
    return make_req(next_rand(), next_rand(), next_rand(),
                    ex_pkg::alu_op_e'(bits[19:16] % 4'd10), use_mult,
                    ex_pkg::mult_ctrl_t'(bits[29:24]));
  endfunction

  task automatic check_value(input string name, input logic [`EX_DATA_W-1:0] expected,
                             input logic [`EX_DATA_W-1:0] actual);
    if (actual !== expected)
    begin
      $display("FAIL at %0t ns: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // One request, result checked one cycle later
  task automatic do_request(input ex_pkg::ex_req_t r);
    logic [`EX_DATA_W-1:0] exp;
    exp       = req_model(r);
    req       = r;
    req_valid = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    req_valid = 1'b0;
    check_value("result_valid_o", 32'd1, result_valid);
    check_value("result_o", exp, result);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    check_value("result_valid_o", 32'd0, result_valid);
    check_value("result_o", 32'd0, result);
    @(posedge clk);
    #DRIVE_DELAY;
    check_value("result_valid_o", 32'd0, result_valid);
    check_value("result_o", 32'd0, result);
  endtask

  task automatic test_alu_ops();
    ex_pkg::alu_op_e op;
    for (int k = 0; k < N_ALU_OPS; k++)
    begin
      op = ex_pkg::alu_op_e'(k);
      for (int i = 0; i < N_CORNER; i++)
      begin
        do_request(make_req(CORNER_A[i], CORNER_B[i], '0, op, 1'b0, '0));
      end
      for (int i = 0; i < N_ALU_RAND; i++)
      begin
        do_request(make_req(next_rand(), next_rand(), next_rand(), op, 1'b0, '0));
      end
    end
  endtask

  // Full words, subword fields ignored, accumulate wraps
  task automatic test_full_mult();
    logic [`EX_DATA_W-1:0] bits;
    for (int m = 0; m < 2; m++)
    begin
      for (int i = 0; i < N_CORNER; i++)
      begin
        do_request(make_req(CORNER_A[i], CORNER_B[i], 32'hffff_ffff - i, ex_pkg::ALU_ADD,
                            1'b1, make_ctrl(1'(m), 1'b0, 2'b00, 2'b00)));
      end
      for (int i = 0; i < N_MUL_RAND; i++)
      begin
        bits = next_rand();
        do_request(make_req(next_rand(), next_rand(), next_rand(), ex_pkg::ALU_SUB, 1'b1,
                            make_ctrl(1'(m), 1'b0, bits[31:30], bits[29:28])));
      end
    end
  endtask

  task automatic test_vector_mult();
    for (int s = 0; s < N_VEC_SETS; s++)
    begin
      for (int sel = 0; sel < 4; sel++)
      begin
        for (int sgn = 0; sgn < 4; sgn++)
        begin
          for (int m = 0; m < 2; m++)
          begin
            do_request(make_req(VEC_A[s], VEC_B[s], VEC_C[s], ex_pkg::ALU_ADD, 1'b1,
                                make_ctrl(1'(m), 1'b1, 2'(sel), 2'(sgn))));
          end
        end
      end
    end
  endtask

  // Burst of mixed requests, then a gap with changing inputs
  task automatic test_stream_idle();
    ex_pkg::ex_req_t       r;
    logic [`EX_DATA_W-1:0] last;
    for (int i = 0; i < N_BURST; i++)
    begin
      r         = random_req(1'(i % 2));
      last      = req_model(r);
      req       = r;
      req_valid = 1'b1;
      @(posedge clk);
      #DRIVE_DELAY;
      check_value("result_valid_o", 32'd1, result_valid);
      check_value("result_o", last, result);
    end
    req_valid = 1'b0;
    for (int i = 0; i < N_GAP; i++)
    begin
      req = random_req(1'(i % 2));
      @(posedge clk);
      #DRIVE_DELAY;
      check_value("result_valid_o", 32'd0, result_valid);
      check_value("result_o", last, result);
    end
    // Stage resumes after the gap
    do_request(random_req(1'b1));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence, watchdog and assertion monitor
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    rng_state = 32'd81669;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    test_reset();
    test_alu_ops();
    test_full_mult();
    test_vector_mult();
    test_stream_idle();
    if (DUT.assert_i.fail_count == 0)
    begin
      $display("TB PASSED");
      $finish;
    end
    else
    begin
      $display("TB FAILED");
      $fatal(1, "assertion failures in the execute stage");
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

  // Stops at the first failing bound assertion
  initial
  begin
    wait (DUT.assert_i.fail_count != 0);
    $display("An assertion on the execute stage failed at %0t ns", $time);
    $display("TB FAILED");
    $fatal(1, "assertion failure");
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
(
  output logic clk_o
);

  // 20 ns period
  localparam int HALF_PERIOD = 10;

  initial
  begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

`default_nettype wire
